//--- rtl/sdram_bank_tracker.sv
module sdram_bank_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::user_req_t  i_pending,
    input  logic                  i_open_valid,
    input  sdram_pkg::bank_t      i_open_bank,
    input  sdram_pkg::row_t       i_open_row,
    input  logic                  i_close_valid,
    input  logic                  i_close_all,
    input  sdram_pkg::bank_t      i_close_bank,
    output sdram_pkg::row_state_e o_row_state
);
    import sdram_pkg::*;

    logic [NUM_BANKS-1:0] open_q;
    row_t                 row_q [NUM_BANKS];
    bank_t                pend_bank;

    assign pend_bank = i_pending.addr.bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (i_close_valid) begin
                if (i_close_all) begin
                    open_q <= '0;
                end else begin
                    open_q[i_close_bank] <= 1'b0;
                end
            end
            if (i_open_valid) begin
                open_q[i_open_bank] <= 1'b1;
            end
        end
    end

    // row latched with each ACTIVE
    always_ff @(posedge clk) begin
        if (i_open_valid) begin
            row_q[i_open_bank] <= i_open_row;
        end
    end

    always_comb begin
        if (!open_q[pend_bank]) begin
            o_row_state = ROW_IDLE;
        end else if (row_q[pend_bank] == i_pending.addr.row) begin
            o_row_state = ROW_HIT;
        end else begin
            o_row_state = ROW_CONFLICT;  // other row open so precharge first
        end
    end

    // sequencer must close a bank before activating it again
    assert property (@(posedge clk) disable iff (rst)
        i_open_valid |-> !open_q[i_open_bank]);

endmodule

//--- rtl/sdram_cmd_sequencer.sv
module sdram_cmd_sequencer #(
    parameter int T_ACT   = 2,
    parameter int T_PRE   = 2,
    parameter int T_REF   = 6,
    parameter int CAS_LAT = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_pkg::user_req_t   i_pending,
    input  logic                   i_pending_valid,
    input  sdram_pkg::row_state_e  i_row_state,
    input  logic                   i_refresh_due,
    input  sdram_pkg::word_t       i_sdram_dqi,
    output logic                   o_take,
    output logic                   o_refresh_ack,
    output logic                   o_open_valid,
    output sdram_pkg::bank_t       o_open_bank,
    output sdram_pkg::row_t        o_open_row,
    output logic                   o_close_valid,
    output logic                   o_close_all,
    output sdram_pkg::bank_t       o_close_bank,
    output sdram_pkg::sdram_pins_t o_sdram,
    output logic                   o_out_valid,
    output sdram_pkg::word_t       o_rdata
);
    import sdram_pkg::*;

    typedef enum logic [3:0] {
        INIT,
        IDLE,
        WAIT,       // NOP gap then jump to next_q
        PRECHARGE,
        REFRESH,
        ACTIVATE,
        READ,
        READ_WAIT,  // CAS latency
        WRITE
    } state_e;

    state_e             state_q;
    state_e             state_d;
    state_e             next_q;
    state_e             next_d;
    logic [DELAY_W-1:0] delay_q;
    logic [DELAY_W-1:0] delay_d;
    logic               pre_all_q;
    logic               pre_all_d;
    logic               out_valid_q;
    logic               out_valid_d;
    logic               capture;
    user_req_t          work_q;
    word_t              rdata_q;
    sdram_pins_t        pins_q;
    sdram_pins_t        pins_d;

    always_comb begin
        state_d     = state_q;
        next_d      = next_q;
        delay_d     = delay_q;
        pre_all_d   = pre_all_q;
        out_valid_d = 1'b0;
        capture     = 1'b0;
        o_take      = 1'b0;

        pins_d       = pins_q;  // cke and dqo hold their value
        pins_d.cmd   = CMD_NOP;
        pins_d.dqm   = 1'b0;
        pins_d.ba    = '0;
        pins_d.a     = '0;
        pins_d.dq_en = 1'b0;

        case (state_q)
            INIT: begin
                pins_d.cke = 1'b1;
                state_d    = IDLE;
            end
            IDLE: begin
                if (i_refresh_due) begin
                    // close everything before auto-refresh
                    pre_all_d = 1'b1;
                    next_d    = REFRESH;
                    state_d   = PRECHARGE;
                end else if (i_pending_valid) begin
                    o_take    = 1'b1;
                    pre_all_d = 1'b0;
                    case (i_row_state)
                        ROW_CONFLICT: begin
                            next_d  = ACTIVATE;
                            state_d = PRECHARGE;
                        end
                        ROW_HIT: state_d = i_pending.rw ? WRITE : READ;
                        default: state_d = ACTIVATE;
                    endcase
                end
            end
            WAIT: begin
                if (delay_q == '0) begin
                    state_d = next_q;
                end else begin
                    delay_d = delay_q - 1'b1;
                end
            end
            PRECHARGE: begin
                pins_d.cmd   = CMD_PRECHARGE;
                pins_d.a[10] = pre_all_q;  // A10 selects all banks
                pins_d.ba    = work_q.addr.bank;
                delay_d      = DELAY_W'(T_PRE);
                state_d      = WAIT;
            end
            REFRESH: begin
                pins_d.cmd = CMD_REFRESH;
                delay_d    = DELAY_W'(T_REF);
                next_d     = IDLE;
                state_d    = WAIT;
            end
            ACTIVATE: begin
                pins_d.cmd = CMD_ACTIVE;
                pins_d.a   = work_q.addr.row;
                pins_d.ba  = work_q.addr.bank;
                delay_d    = DELAY_W'(T_ACT);
                next_d     = work_q.rw ? WRITE : READ;
                state_d    = WAIT;
            end
            READ: begin
                pins_d.cmd = CMD_READ;
                pins_d.a   = {2'b00, 1'b0, work_q.addr.col, 2'b00};
                pins_d.ba  = work_q.addr.bank;
                delay_d    = DELAY_W'(CAS_LAT);
                state_d    = READ_WAIT;
            end
            READ_WAIT: begin
                if (delay_q == '0) begin
                    capture     = 1'b1;  // dqi valid this cycle
                    out_valid_d = 1'b1;
                    state_d     = IDLE;
                end else begin
                    delay_d = delay_q - 1'b1;
                end
            end
            WRITE: begin
                pins_d.cmd   = CMD_WRITE;
                pins_d.a     = {2'b00, 1'b0, work_q.addr.col, 2'b00};
                pins_d.ba    = work_q.addr.bank;
                pins_d.dq_en = 1'b1;
                pins_d.dqo   = work_q.wdata;
                delay_d      = '0;
                next_d       = IDLE;
                state_d      = WAIT;
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= INIT;
            next_q      <= IDLE;
            delay_q     <= '0;
            pre_all_q   <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            next_q      <= next_d;
            delay_q     <= delay_d;
            pre_all_q   <= pre_all_d;
            out_valid_q <= out_valid_d;
        end
    end

    // address and data fields follow pins_d while control fields get reset
    always_ff @(posedge clk) begin
        pins_q <= pins_d;
        if (rst) begin
            pins_q.cke   <= 1'b0;
            pins_q.cmd   <= CMD_NOP;
            pins_q.dq_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_take) begin
            work_q <= i_pending;
        end
        if (capture) begin
            rdata_q <= i_sdram_dqi;
        end
    end

    // tracker and refresh timer follow the command as it is registered
    assign o_open_valid  = (state_q == ACTIVATE);
    assign o_open_bank   = work_q.addr.bank;
    assign o_open_row    = work_q.addr.row;
    assign o_close_valid = (state_q == PRECHARGE);
    assign o_close_all   = pre_all_q;
    assign o_close_bank  = work_q.addr.bank;
    assign o_refresh_ack = (state_q == PRECHARGE) && pre_all_q;

    assign o_sdram     = pins_q;
    assign o_out_valid = out_valid_q;
    assign o_rdata     = rdata_q;

    // write data only ever rides along with a write command
    assert property (@(posedge clk) disable iff (rst)
        pins_q.dq_en |-> pins_q.cmd == CMD_WRITE);

    // each read on the pins returns one cycle after its data
    assert property (@(posedge clk) disable iff (rst)
        pins_q.cmd == CMD_READ |-> ##(CAS_LAT + 1) o_out_valid);

endmodule

//--- rtl/sdram_ctrl_top.sv
module sdram_ctrl_top #(
    parameter int T_ACT            = 2,
    parameter int T_PRE            = 2,
    parameter int T_REF            = 6,
    parameter int CAS_LAT          = 3,
    parameter int REFRESH_INTERVAL = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_in_valid,
    input  sdram_pkg::user_req_t   i_req,
    input  sdram_pkg::word_t       i_sdram_dqi,
    output logic                   o_busy,
    output logic                   o_out_valid,
    output sdram_pkg::word_t       o_rdata,
    output sdram_pkg::sdram_pins_t o_sdram
);
    import sdram_pkg::*;

    user_req_t  pending;
    logic       pending_valid;
    logic       take;
    logic       refresh_due;
    logic       refresh_ack;
    row_state_e row_state;
    logic       open_valid;
    bank_t      open_bank;
    row_t       open_row;
    logic       close_valid;
    logic       close_all;
    bank_t      close_bank;

    sdram_request_queue u_queue (
        .clk             (clk),
        .rst             (rst),
        .i_in_valid      (i_in_valid),
        .i_req           (i_req),
        .i_take          (take),
        .o_busy          (o_busy),
        .o_pending       (pending),
        .o_pending_valid (pending_valid)
    );

    sdram_refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) u_refresh (
        .clk           (clk),
        .rst           (rst),
        .i_refresh_ack (refresh_ack),
        .o_refresh_due (refresh_due)
    );

    sdram_bank_tracker u_banks (
        .clk           (clk),
        .rst           (rst),
        .i_pending     (pending),
        .i_open_valid  (open_valid),
        .i_open_bank   (open_bank),
        .i_open_row    (open_row),
        .i_close_valid (close_valid),
        .i_close_all   (close_all),
        .i_close_bank  (close_bank),
        .o_row_state   (row_state)
    );

    sdram_cmd_sequencer #(
        .T_ACT   (T_ACT),
        .T_PRE   (T_PRE),
        .T_REF   (T_REF),
        .CAS_LAT (CAS_LAT)
    ) u_seq (
        .clk             (clk),
        .rst             (rst),
        .i_pending       (pending),
        .i_pending_valid (pending_valid),
        .i_row_state     (row_state),
        .i_refresh_due   (refresh_due),
        .i_sdram_dqi     (i_sdram_dqi),
        .o_take          (take),
        .o_refresh_ack   (refresh_ack),
        .o_open_valid    (open_valid),
        .o_open_bank     (open_bank),
        .o_open_row      (open_row),
        .o_close_valid   (close_valid),
        .o_close_all     (close_all),
        .o_close_bank    (close_bank),
        .o_sdram         (o_sdram),
        .o_out_valid     (o_out_valid),
        .o_rdata         (o_rdata)
    );

endmodule

//--- rtl/sdram_pkg.sv
package sdram_pkg;

    // address split with the row on top as in the user address
    localparam int ROW_W  = 13;
    localparam int BANK_W = 2;
    localparam int COL_W  = 8;
    localparam int WORD_W = 32;

    localparam int NUM_BANKS = 4;
    localparam int DELAY_W   = 4;  // big enough for T_REF and CAS_LAT

    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        row_t  row;
        bank_t bank;
        col_t  col;
    } user_addr_t;

    // encoded as {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_REFRESH    = 4'b0001,
        CMD_PRECHARGE  = 4'b0010,
        CMD_ACTIVE     = 4'b0011,
        CMD_WRITE      = 4'b0100,
        CMD_READ       = 4'b0101,
        CMD_NOP        = 4'b0111,
        CMD_UNSELECTED = 4'b1000  // chip not selected
    } sdram_cmd_e;

    // everything that goes out to the device pins
    typedef struct packed {
        logic       cke;
        sdram_cmd_e cmd;
        logic       dqm;
        bank_t      ba;
        logic [12:0] a;
        logic       dq_en;  // dqo is only meaningful while set
        word_t      dqo;
    } sdram_pins_t;

    typedef struct packed {
        logic       rw;     // 1 = write
        user_addr_t addr;
        word_t      wdata;
    } user_req_t;

    // open-row lookup for the pending request
    typedef enum logic [1:0] {
        ROW_IDLE     = 2'd0,
        ROW_HIT      = 2'd1,
        ROW_CONFLICT = 2'd2
    } row_state_e;

endpackage

//--- rtl/sdram_refresh_timer.sv
module sdram_refresh_timer #(
    parameter int REFRESH_INTERVAL = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic i_refresh_ack,
    output logic o_refresh_due
);
    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             due_q;

    always_ff @(posedge clk) begin
        if (rst || i_refresh_ack) begin
            cnt_q <= '0;  // restart the interval
            due_q <= 1'b0;
        end else if (!due_q) begin
            if (cnt_q == CNT_W'(REFRESH_INTERVAL - 1)) begin
                due_q <= 1'b1;  // sticky until acked
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign o_refresh_due = due_q;

endmodule

//--- rtl/sdram_request_queue.sv
module sdram_request_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_in_valid,
    input  sdram_pkg::user_req_t i_req,
    input  logic                 i_take,
    output logic                 o_busy,
    output sdram_pkg::user_req_t o_pending,
    output logic                 o_pending_valid
);
    import sdram_pkg::*;

    user_req_t req_q;
    logic      full_q;
    logic      accept;

    // only take a new request into an empty slot
    assign accept = i_in_valid && !full_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (i_take) begin
            full_q <= 1'b0;  // sequencer has copied it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_req;
        end
    end

    assign o_busy          = full_q;
    assign o_pending       = req_q;
    assign o_pending_valid = full_q;

    // sequencer may only pull a request that is actually waiting
    assert property (@(posedge clk) disable iff (rst)
        i_take |-> full_q);

endmodule

//--- sim/sdram_model.sv
module sdram_model #(
    parameter int T_ACT   = 2,
    parameter int T_PRE   = 2,
    parameter int T_REF   = 6,
    parameter int CAS_LAT = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_pkg::sdram_pins_t i_pins,
    output sdram_pkg::word_t       o_dqi,
    output int                     o_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import sdram_pkg::*;

    word_t                mem [logic [22:0]];  // keyed by {row, bank, col}
    logic [NUM_BANKS-1:0] open_q;
    row_t                 row_q [NUM_BANKS];
    word_t                rd_pipe [CAS_LAT];
    int                   nop_cnt;   // NOP cycles since the last command
    int                   need_gap;  // NOPs owed to the last command
    logic                 is_cmd;
    logic [22:0]          key;

    assign is_cmd = !(i_pins.cmd inside {CMD_NOP, CMD_UNSELECTED});
    assign key    = {row_q[i_pins.ba], i_pins.ba, i_pins.a[9:2]};
    assign o_dqi  = rd_pipe[CAS_LAT-1];

    initial o_errors = 0;

    function automatic int gap_after(sdram_cmd_e cmd);
        case (cmd)
            CMD_ACTIVE:    return T_ACT + 1;
            CMD_PRECHARGE: return T_PRE + 1;
            CMD_REFRESH:   return T_REF + 1;
            CMD_WRITE:     return 1;
            default:       return 0;
        endcase
    endfunction

    task automatic note_violation(string msg);
        $display("[ERROR] %0t: model saw %s", $time, msg);
        o_errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            open_q   <= '0;
            nop_cnt  <= 0;
            need_gap <= 0;
        end else begin
            nop_cnt  <= is_cmd ? 0 : nop_cnt + 1;
            need_gap <= is_cmd ? gap_after(i_pins.cmd) : need_gap;
            case (i_pins.cmd)
                CMD_ACTIVE: begin
                    open_q[i_pins.ba] <= 1'b1;
                    row_q[i_pins.ba]  <= i_pins.a;
                end
                CMD_PRECHARGE: begin
                    if (i_pins.a[10]) begin
                        open_q <= '0;  // precharge all
                    end else begin
                        open_q[i_pins.ba] <= 1'b0;
                    end
                end
                CMD_WRITE: begin
                    if (!i_pins.dqm) begin
                        mem[key] = i_pins.dqo;  // dqm masks the whole word
                    end
                end
                default: ;
            endcase
        end
    end

    // read data walks down the pipe and unwritten words read back their own address
    always @(posedge clk) begin
        rd_pipe[0] <= (i_pins.cmd == CMD_READ) ? (mem.exists(key) ? mem[key] : 32'(key)) : 'x;
        for (int i = 1; i < CAS_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        i_pins.cmd == CMD_ACTIVE |-> !open_q[i_pins.ba])
        else note_violation("ACTIVE to a bank that is already open");
    assert property (@(posedge clk) disable iff (rst)
        i_pins.cmd inside {CMD_READ, CMD_WRITE} |-> open_q[i_pins.ba])
        else note_violation("READ or WRITE to a closed bank");
    assert property (@(posedge clk) disable iff (rst)
        i_pins.cmd == CMD_REFRESH |-> open_q == '0)
        else note_violation("REFRESH with a bank still open");
    assert property (@(posedge clk) disable iff (rst)
        is_cmd |-> nop_cnt >= need_gap)
        else note_violation("a command too soon after the previous one");

endmodule

//--- sim/tb_sdram_ctrl.sv
module tb_sdram_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import sdram_pkg::*;

    localparam int T_ACT            = 2;
    localparam int T_PRE            = 2;
    localparam int T_REF            = 6;
    localparam int CAS_LAT          = 3;
    localparam int REFRESH_INTERVAL = 64;
    localparam int TIMEOUT          = 2000;  // cycles per wait

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    user_req_t   req;
    logic        busy;
    logic        out_valid;
    word_t       rdata;
    sdram_pins_t pins;
    word_t       dqi;
    int          model_errors;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [15:0] lfsr = 16'd53192;
    word_t       exp_mem [logic [22:0]];  // written words by user address
    word_t       exp_rd [0:1023];         // expected read results in order
    int          wr_idx = 0;              // reads accepted
    int          rd_idx = 0;              // reads returned
    int          ref_gap = 0;

    sdram_ctrl_top dut (
        .clk         (clk),
        .rst         (rst),
        .i_in_valid  (in_valid),
        .i_req       (req),
        .i_sdram_dqi (dqi),
        .o_busy      (busy),
        .o_out_valid (out_valid),
        .o_rdata     (rdata),
        .o_sdram     (pins)
    );

    sdram_model #(.T_ACT(T_ACT), .T_PRE(T_PRE), .T_REF(T_REF), .CAS_LAT(CAS_LAT)) u_model (
        .clk      (clk),
        .rst      (rst),
        .i_pins   (pins),
        .o_dqi    (dqi),
        .o_errors (model_errors)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (out_valid) rd_idx <= rd_idx + 1;
        ref_gap <= (rst || pins.cmd == CMD_REFRESH) ? 0 : ref_gap + 1;
    end

    task automatic log_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors++;
    endtask

    assert property (@(posedge clk) $fell(rst) |->
        (!busy && !out_valid && pins.cmd == CMD_NOP && !pins.dq_en && !pins.cke) ##1 pins.cke)
        else log_error("outputs wrong right after reset");
    assert property (@(posedge clk) disable iff (rst) $past(!rst) |-> pins.cke)
        else log_error("cke low after the first cycle");
    assert property (@(posedge clk) disable iff (rst) out_valid |-> rd_idx < wr_idx)
        else log_error("o_out_valid with no accepted read left");
    assert property (@(posedge clk) disable iff (rst)
        out_valid && rd_idx < wr_idx |-> rdata == exp_rd[rd_idx])
        else log_error($sformatf("read data %h, expected %h",
            $sampled(rdata), exp_rd[$sampled(rd_idx)]));
    assert property (@(posedge clk) disable iff (rst) ref_gap <= REFRESH_INTERVAL + 40)
        else log_error("no REFRESH within the refresh interval");

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic give_up(string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic wait_busy(logic level, string what);
        int n = 0;
        while (busy !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) give_up(what);
    endtask

    task automatic send_req(logic rw, row_t row, bank_t bank, col_t col, word_t wdata);
        user_addr_t a;
        a = '{row: row, bank: bank, col: col};
        wait_busy(1'b0, "o_busy to drop");
        in_valid = 1'b1;
        req      = '{rw: rw, addr: a, wdata: wdata};
        if (rw) begin
            exp_mem[a] = wdata;
        end else begin
            exp_rd[wr_idx] = exp_mem.exists(a) ? exp_mem[a] : {9'd0, a};  // fill is the address
            wr_idx++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int n = 0;
        while ((busy || rd_idx != wr_idx) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy || rd_idx != wr_idx) give_up("outstanding reads to return");
        repeat (8) @(negedge clk);  // room for a stray o_out_valid
    endtask

    task automatic end_test(string name, int start);
        int n = errors + model_errors - start;
        $display("test %s: %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
        tests_run++;
        if (n != 0) tests_failed++;
    endtask

    initial begin
        int    start;
        logic  rw;
        row_t  row;
        bank_t bank;
        col_t  col;
        word_t data;
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        start = errors + model_errors;
        repeat (4) @(negedge clk);
        end_test("reset", start);

        start = errors + model_errors;
        send_req(1'b1, 13'd1, 2'd1, 8'd5, 32'h1234_5678);  // bank idle
        send_req(1'b0, 13'd1, 2'd1, 8'd5, '0);             // row hit
        send_req(1'b0, 13'd1, 2'd1, 8'd6, '0);             // never written
        send_req(1'b0, 13'd2, 2'd1, 8'd5, '0);             // conflict
        send_req(1'b0, 13'd1, 2'd1, 8'd5, '0);             // conflict back
        drain();
        end_test("hit_idle_conflict", start);

        start = errors + model_errors;
        send_req(1'b0, 13'd3, 2'd2, 8'd1, '0);
        send_req(1'b0, 13'd3, 2'd2, 8'd2, '0);  // waits in the queue
        wait_busy(1'b1, "o_busy to rise");
        in_valid = 1'b1;  // offered while busy and must vanish
        req      = '{rw: 1'b1, addr: '{row: 13'd3, bank: 2'd2, col: 8'd1}, wdata: 32'hdead_beef};
        @(negedge clk);
        in_valid = 1'b0;
        send_req(1'b0, 13'd3, 2'd2, 8'd1, '0);
        drain();
        end_test("busy_reject", start);

        start = errors + model_errors;
        for (int i = 0; i < 200; i++) begin
            rw   = 1'(rand_bits(1));
            row  = 13'(rand_bits(2));  // few rows so hits and conflicts mix
            bank = 2'(rand_bits(2));
            col  = 8'(rand_bits(3));
            data = rand_bits(32);
            send_req(rw, row, bank, col, data);
        end
        drain();
        end_test("random_traffic", start);

        start = errors + model_errors;
        assert (rd_idx == wr_idx)
            else log_error($sformatf("%0d reads accepted, %0d returned", wr_idx, rd_idx));
        end_test("read_count", start);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
            errors + model_errors);
        if (tests_failed == 0 && errors + model_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/sdram_pkg.sv
rtl/sdram_request_queue.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_bank_tracker.sv
rtl/sdram_cmd_sequencer.sv
rtl/sdram_ctrl_top.sv
sim/sdram_model.sv
sim/tb_sdram_ctrl.sv
